// File: logic/cabinet_cfg_pkg.sv
// Cabinet configuration definitions
// Game codes, download indices and the download write bundle

package cabinet_cfg_pkg;

	// ====================
	// Game selection
	// ====================

	// Codes as carried in the download byte at index 1
	typedef enum logic [7:0] {
		GAME_NONE          = 8'd0,
		GAME_SPACE_ZAP     = 8'd3,
		GAME_WIZARD_OF_WOR = 8'd5,
		GAME_ROBBY_ROTO    = 8'd6
	} game_e;

	// ====================
	// Download channel
	// ====================

	localparam logic [7:0] IDX_GAME_SELECT = 8'd1;   // Game code byte
	localparam logic [7:0] IDX_DIP         = 8'd254; // DIP switch bank

	// One DIP byte. The bank is an unpacked array of these,
	// sized by NUM_DIP_BYTES in the modules that hold or read it
	typedef logic [7:0] dip_byte_t;

	// One download write, 42 bits
	typedef struct packed {
		logic        strobe; // Write valid this cycle
		logic [7:0]  index;  // Target of the download
		logic [24:0] addr;   // Byte address within the target
		logic [7:0]  data;   // Payload byte
	} dl_write_t;

endpackage

// File: logic/control_pkg.sv
// Player control definitions
// Button and joystick bundles, PS/2 key codes, switch matrix columns

package control_pkg;

	// Held state of one player's buttons, all active high
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire_a;
		logic fire_b;
		logic start;
		logic coin;
	} player_buttons_t;

	// Digital joystick word, right at bit 0
	typedef struct packed {
		logic [6:0] unused;
		logic       coin;    // Bit 8
		logic       start_2;
		logic       start_1;
		logic       fire_b;
		logic       fire_a;  // Bit 4
		logic       up;
		logic       down;
		logic       left;
		logic       right;   // Bit 0
	} joystick_t;

	// Keyboard event, a new event flips toggle
	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic [8:0] code;    // Bit 8 is the extended prefix
	} ps2_event_t;

	// ====================
	// Matrix columns
	// ====================
	localparam logic [7:0] COL_0    = 8'h01;
	localparam logic [7:0] COL_1    = 8'h02;
	localparam logic [7:0] COL_2    = 8'h04;
	localparam logic [7:0] COL_3    = 8'h08;
	localparam logic [7:0] ROW_IDLE = 8'hFF; // Nothing pressed

	// Arrow keys, matched on the low byte only
	localparam logic [7:0] KEY_ARROW_UP    = 8'h75;
	localparam logic [7:0] KEY_ARROW_DOWN  = 8'h72;
	localparam logic [7:0] KEY_ARROW_LEFT  = 8'h6B;
	localparam logic [7:0] KEY_ARROW_RIGHT = 8'h74;

	// Full 9-bit codes
	localparam logic [8:0] KEY_CTRL  = 9'h014; // P1 fire A
	localparam logic [8:0] KEY_SPACE = 9'h029; // P1 fire B
	localparam logic [8:0] KEY_F1    = 9'h005; // P1 start
	localparam logic [8:0] KEY_1     = 9'h016; // P1 start, MAME style
	localparam logic [8:0] KEY_F3    = 9'h004; // Coin
	localparam logic [8:0] KEY_5     = 9'h02E; // Coin, MAME style
	localparam logic [8:0] KEY_F2    = 9'h006; // P2 start
	localparam logic [8:0] KEY_2     = 9'h01E; // P2 start, MAME style
	localparam logic [8:0] KEY_R     = 9'h02D; // P2 up
	localparam logic [8:0] KEY_F     = 9'h02B; // P2 down
	localparam logic [8:0] KEY_D     = 9'h023; // P2 left
	localparam logic [8:0] KEY_G     = 9'h034; // P2 right
	localparam logic [8:0] KEY_A     = 9'h01C; // P2 fire A
	localparam logic [8:0] KEY_S     = 9'h01B; // P2 fire B

endpackage

// File: logic/game_config.sv
// Configuration loader
// Captures the game code and DIP switch bytes from download writes

`timescale 1ns/1ps

module game_config #(
	parameter int NUM_DIP_BYTES = 8
) (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  cabinet_cfg_pkg::dl_write_t dl,
	output cabinet_cfg_pkg::game_e     game,
	output cabinet_cfg_pkg::dip_byte_t dips [NUM_DIP_BYTES]
);

	// Index bits needed to address the bank
	localparam int DIP_AW = (NUM_DIP_BYTES > 1) ? $clog2(NUM_DIP_BYTES) : 1;

	logic [7:0] game_raw; // Code as downloaded
	logic       game_hit;
	logic       dip_hit;

	// Unknown codes fall back to no game
	function automatic cabinet_cfg_pkg::game_e decode_game(input logic [7:0] code);
		case (code)
			cabinet_cfg_pkg::GAME_SPACE_ZAP,
			cabinet_cfg_pkg::GAME_WIZARD_OF_WOR,
			cabinet_cfg_pkg::GAME_ROBBY_ROTO:
				decode_game = cabinet_cfg_pkg::game_e'(code);
			default:
				decode_game = cabinet_cfg_pkg::GAME_NONE;
		endcase
	endfunction

	// ====================
	// Write decode
	// ====================
	assign game_hit = dl.strobe && (dl.index == cabinet_cfg_pkg::IDX_GAME_SELECT);
	assign dip_hit  = dl.strobe && (dl.index == cabinet_cfg_pkg::IDX_DIP)
		&& (dl.addr < 25'(NUM_DIP_BYTES)); // Out of range writes are dropped

	// Raw byte first, decoded game one cycle later
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			game_raw <= 8'd0;
			game     <= cabinet_cfg_pkg::GAME_NONE;
		end else begin
			if (game_hit)
				game_raw <= dl.data;
			game <= decode_game(game_raw);
		end
	end

	// ====================
	// DIP bank
	// ====================
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < NUM_DIP_BYTES; i++) begin
				dips[i] <= 8'd0;
			end
		end else if (dip_hit) begin
			dips[dl.addr[DIP_AW-1:0]] <= dl.data; // Visible right after the write edge
		end
	end

endmodule

// File: logic/key_decoder.sv
// PS/2 key decoder
// Turns key press and release events into held button states for both players

`timescale 1ns/1ps

module key_decoder (
	input  logic                          clk_sys,
	input  logic                          reset,
	input  control_pkg::ps2_event_t       key,
	output control_pkg::player_buttons_t  key_p1,
	output control_pkg::player_buttons_t  key_p2
);

	control_pkg::ps2_event_t key_q;     // Event as sampled
	logic                    toggle_q;  // Toggle of the previous sample
	logic                    new_event;

	// ====================
	// Event detect
	// ====================
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			key_q    <= '0;
			toggle_q <= 1'b0;
		end else begin
			key_q    <= key;
			toggle_q <= key_q.toggle;
		end
	end

	assign new_event = key_q.toggle ^ toggle_q; // One cycle per flip

	// ====================
	// Button state
	// ====================
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			key_p1 <= '0;
			key_p2 <= '0;
		end else if (new_event) begin
			casez (key_q.code)
				// Arrows, extended prefix don't care
				{1'b?, control_pkg::KEY_ARROW_UP}:    key_p1.up    <= key_q.pressed;
				{1'b?, control_pkg::KEY_ARROW_DOWN}:  key_p1.down  <= key_q.pressed;
				{1'b?, control_pkg::KEY_ARROW_LEFT}:  key_p1.left  <= key_q.pressed;
				{1'b?, control_pkg::KEY_ARROW_RIGHT}: key_p1.right <= key_q.pressed;

				control_pkg::KEY_CTRL:  key_p1.fire_a <= key_q.pressed;
				control_pkg::KEY_SPACE: key_p1.fire_b <= key_q.pressed;

				// Two keys each for start and coin
				control_pkg::KEY_F1,
				control_pkg::KEY_1:     key_p1.start  <= key_q.pressed;
				control_pkg::KEY_F3,
				control_pkg::KEY_5:     key_p1.coin   <= key_q.pressed;
				control_pkg::KEY_F2,
				control_pkg::KEY_2:     key_p2.start  <= key_q.pressed;

				// Player 2 on the left hand block
				control_pkg::KEY_R:     key_p2.up     <= key_q.pressed;
				control_pkg::KEY_F:     key_p2.down   <= key_q.pressed;
				control_pkg::KEY_D:     key_p2.left   <= key_q.pressed;
				control_pkg::KEY_G:     key_p2.right  <= key_q.pressed;
				control_pkg::KEY_A:     key_p2.fire_a <= key_q.pressed;
				control_pkg::KEY_S:     key_p2.fire_b <= key_q.pressed;

				default: ; // Unknown key, hold everything
			endcase
		end
	end

endmodule

// File: logic/switch_matrix.sv
// Switch matrix
// Merges key and joystick buttons, answers a column select with the game's row

`timescale 1ns/1ps

module switch_matrix #(
	parameter int NUM_DIP_BYTES = 8
) (
	input  cabinet_cfg_pkg::game_e        game,
	input  cabinet_cfg_pkg::dip_byte_t    dips [NUM_DIP_BYTES],
	input  control_pkg::player_buttons_t  key_p1,
	input  control_pkg::player_buttons_t  key_p2,
	input  control_pkg::joystick_t        joy_1,
	input  control_pkg::joystick_t        joy_2,
	input  logic [7:0]                    col_select,
	output logic [7:0]                    row_data
);

	localparam logic SPEECH_READY = 1'b1; // No speech chip, always ready

	control_pkg::player_buttons_t p1;  // Merged player 1
	control_pkg::player_buttons_t p2;  // Merged player 2
	logic [7:0] dip2;
	logic [7:0] dip3;
	logic [3:0] dir_p1;                // R, L, D, U active low
	logic [3:0] dir_p2;
	logic [7:0] ct0_sz, ct1_sz, ct2_sz;
	logic [7:0] ct0_rr, ct1_rr, ct2_rr;
	logic [7:0] ct0_ww, ct1_ww, ct2_ww;

	// Stick and fire of one player, start and coin filled in later
	function automatic control_pkg::player_buttons_t merge_stick(
		input control_pkg::player_buttons_t k,
		input control_pkg::joystick_t       j
	);
		control_pkg::player_buttons_t m;
		m        = '0;
		m.up     = k.up     | j.up;
		m.down   = k.down   | j.down;
		m.left   = k.left   | j.left;
		m.right  = k.right  | j.right;
		m.fire_a = k.fire_a | j.fire_a;
		m.fire_b = k.fire_b | j.fire_b;
		return m;
	endfunction

	// ====================
	// Button merge
	// ====================
	always_comb begin
		p1 = merge_stick(key_p1, joy_1);
		p2 = merge_stick(key_p2, joy_2);
		// Start and coin only from the first stick
		p1.start = key_p1.start | joy_1.start_1;
		p1.coin  = key_p1.coin  | joy_1.coin;
		p2.start = key_p2.start | joy_1.start_2;
	end

	assign dip2   = dips[2];
	assign dip3   = dips[3];
	assign dir_p1 = ~{p1.right, p1.left, p1.down, p1.up};
	assign dir_p2 = ~{p2.right, p2.left, p2.down, p2.up};

	// ====================
	// Row bytes, bit 7 first
	// ====================

	// Space Zap
	assign ct0_sz = {2'b11, ~p2.start, ~p1.start, dip2[1], 1'b1, ~p1.coin, 1'b1};
	assign ct1_sz = {3'b111, ~p2.fire_a, dir_p2};
	assign ct2_sz = {2'b11, dip2[0], ~p1.fire_a, dir_p1};

	// Robby Roto
	assign ct0_rr = {1'b0, ~p2.start, ~p1.start, 1'b1, dip2[1], 1'b1, ~p1.coin, 1'b1};
	assign ct1_rr = {2'b11, ~p2.fire_a, 1'b1, dir_p2};
	assign ct2_rr = {2'b11, ~p1.fire_a, 1'b1, dir_p1};

	// Wizard of Wor, fire B reads active high
	assign ct0_ww = {dip2[2], ~p2.start, ~p1.start, 1'b1, dip2[1], 1'b1, ~p1.coin, 1'b1};
	assign ct1_ww = {2'b11, ~p2.fire_a, p2.fire_b, dir_p2};
	assign ct2_ww = {SPEECH_READY, 1'b1, ~p1.fire_a, p1.fire_b, dir_p1};

	// ====================
	// Column mux
	// ====================
	always_comb begin
		row_data = control_pkg::ROW_IDLE;
		if (game != cabinet_cfg_pkg::GAME_NONE) begin
			case (col_select)
				control_pkg::COL_0:
					case (game)
						cabinet_cfg_pkg::GAME_SPACE_ZAP:     row_data = ct0_sz;
						cabinet_cfg_pkg::GAME_ROBBY_ROTO:    row_data = ct0_rr;
						cabinet_cfg_pkg::GAME_WIZARD_OF_WOR: row_data = ct0_ww;
						default:                             row_data = control_pkg::ROW_IDLE;
					endcase
				control_pkg::COL_1:
					case (game)
						cabinet_cfg_pkg::GAME_SPACE_ZAP:     row_data = ct1_sz;
						cabinet_cfg_pkg::GAME_ROBBY_ROTO:    row_data = ct1_rr;
						cabinet_cfg_pkg::GAME_WIZARD_OF_WOR: row_data = ct1_ww;
						default:                             row_data = control_pkg::ROW_IDLE;
					endcase
				control_pkg::COL_2:
					case (game)
						cabinet_cfg_pkg::GAME_SPACE_ZAP:     row_data = ct2_sz;
						cabinet_cfg_pkg::GAME_ROBBY_ROTO:    row_data = ct2_rr;
						cabinet_cfg_pkg::GAME_WIZARD_OF_WOR: row_data = ct2_ww;
						default:                             row_data = control_pkg::ROW_IDLE;
					endcase
				control_pkg::COL_3: row_data = dip3; // Same DIP byte for every game
				default:            row_data = control_pkg::ROW_IDLE;
			endcase
		end
	end

endmodule

// File: logic/cabinet_inputs.sv
// Cabinet input block
// Download config, keyboard decode and the CPU-facing switch matrix

`timescale 1ns/1ps

module cabinet_inputs #(
	parameter int NUM_DIP_BYTES = 8 // At least 4, matrix reads bytes 2 and 3
) (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  cabinet_cfg_pkg::dl_write_t dl,
	input  control_pkg::ps2_event_t    key,
	input  control_pkg::joystick_t     joy_1,
	input  control_pkg::joystick_t     joy_2,
	input  logic [7:0]                 col_select,
	output logic [7:0]                 row_data
);

	cabinet_cfg_pkg::game_e        game;
	cabinet_cfg_pkg::dip_byte_t    dips [NUM_DIP_BYTES];
	control_pkg::player_buttons_t  key_p1;
	control_pkg::player_buttons_t  key_p2;

	// ====================
	// Config loader
	// ====================
	game_config #(
		.NUM_DIP_BYTES(NUM_DIP_BYTES)
	) u_game_config (
		.clk_sys (clk_sys),
		.reset   (reset),
		.dl      (dl),
		.game    (game),   // Two cycles from write
		.dips    (dips)
	);

	// Keyboard
	key_decoder u_key_decoder (
		.clk_sys (clk_sys),
		.reset   (reset),
		.key     (key),
		.key_p1  (key_p1),
		.key_p2  (key_p2)
	);

	// ====================
	// Matrix, combinational
	// ====================
	switch_matrix #(
		.NUM_DIP_BYTES(NUM_DIP_BYTES)
	) u_switch_matrix (
		.game       (game),
		.dips       (dips),
		.key_p1     (key_p1),
		.key_p2     (key_p2),
		.joy_1      (joy_1),
		.joy_2      (joy_2),
		.col_select (col_select),
		.row_data   (row_data)
	);

endmodule

// File: dv/tb_cabinet_inputs.sv
// Cabinet input block testbench
// Directed tests of download config, key decode and the switch matrix rows

`timescale 1ns/1ps

module tb_cabinet_inputs;

	localparam int CLK_PERIOD    = 100;
	localparam int NUM_DIP_BYTES = 8;
	// Reset, config tests, two key sweeps, two random runs
	localparam int TEST_CYCLES   = 8 + 40 + 2 * (18 * 12 + 20) + 2 * (2 + 50);
	localparam int MARGIN_CYCLES = 200;

	// Key table, arrows given with and without the extended prefix
	localparam logic [8:0] KEY_CODES [18] = '{9'h175, 9'h072, 9'h16B, 9'h174, 9'h014, 9'h029,
		9'h005, 9'h016, 9'h004, 9'h02E, 9'h006, 9'h01E, 9'h02D, 9'h02B, 9'h023, 9'h034,
		9'h01C, 9'h01B};
	// Bit 8 set for player 2, low byte is the button in player_buttons_t order
	localparam logic [8:0] KEY_BTN [18] = '{9'h080, 9'h040, 9'h020, 9'h010, 9'h008, 9'h004,
		9'h002, 9'h002, 9'h001, 9'h001, 9'h102, 9'h102, 9'h180, 9'h140, 9'h120, 9'h110,
		9'h108, 9'h104};

	logic                         clk_sys;
	logic                         reset;
	cabinet_cfg_pkg::dl_write_t   dl;
	control_pkg::ps2_event_t      key;
	control_pkg::joystick_t       joy_1;
	control_pkg::joystick_t       joy_2;
	logic [7:0]                   col_select;
	logic [7:0]                   row_data;

	cabinet_cfg_pkg::game_e cur_game; // Game the DUT should hold
	logic [7:0]             dip2_exp;
	logic [7:0]             dip3_exp;
	logic [31:0]            lcg_state;
	int                     errors;
	int                     checks;

	cabinet_inputs #(
		.NUM_DIP_BYTES(NUM_DIP_BYTES)
	) dut (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl         (dl),
		.key        (key),
		.joy_1      (joy_1),
		.joy_2      (joy_2),
		.col_select (col_select),
		.row_data   (row_data)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	// ====================
	// Reference model
	// ====================
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// Merged buttons of one stick, start and coin passed in
	function automatic control_pkg::player_buttons_t stick_buttons(
		input control_pkg::joystick_t j, input logic start, input logic coin);
		return {j.up, j.down, j.left, j.right, j.fire_a, j.fire_b, start, coin};
	endfunction

	// Row byte from the column tables, a is player 1 and b player 2
	function automatic logic [7:0] expected_row(input cabinet_cfg_pkg::game_e g,
		input logic [7:0] col, input control_pkg::player_buttons_t a,
		input control_pkg::player_buttons_t b);
		logic [3:0] d1;
		logic [3:0] d2;
		logic [7:0] zap;
		logic [7:0] robby;
		logic [7:0] wizard;
		d1 = ~{a.right, a.left, a.down, a.up};
		d2 = ~{b.right, b.left, b.down, b.up};
		zap = 8'hFF;
		robby = 8'hFF;
		wizard = 8'hFF;
		if (col == control_pkg::COL_0) begin
			zap    = {2'b11, ~b.start, ~a.start, dip2_exp[1], 1'b1, ~a.coin, 1'b1};
			robby  = {1'b0, ~b.start, ~a.start, 1'b1, dip2_exp[1], 1'b1, ~a.coin, 1'b1};
			wizard = {dip2_exp[2], ~b.start, ~a.start, 1'b1, dip2_exp[1], 1'b1, ~a.coin, 1'b1};
		end else if (col == control_pkg::COL_1) begin
			zap    = {3'b111, ~b.fire_a, d2};
			robby  = {2'b11, ~b.fire_a, 1'b1, d2};
			wizard = {2'b11, ~b.fire_a, b.fire_b, d2};  // Fire B not inverted
		end else if (col == control_pkg::COL_2) begin
			zap    = {2'b11, dip2_exp[0], ~a.fire_a, d1};
			robby  = {2'b11, ~a.fire_a, 1'b1, d1};
			wizard = {2'b11, ~a.fire_a, a.fire_b, d1};  // Speech ready high
		end else if (col == control_pkg::COL_3) begin
			zap    = dip3_exp;
			robby  = dip3_exp;
			wizard = dip3_exp;
		end
		case (g)
			cabinet_cfg_pkg::GAME_SPACE_ZAP:     return zap;
			cabinet_cfg_pkg::GAME_ROBBY_ROTO:    return robby;
			cabinet_cfg_pkg::GAME_WIZARD_OF_WOR: return wizard;
			default:                             return 8'hFF;
		endcase
	endfunction

	// ====================
	// Drive and compare
	// ====================
	task automatic tick();
		@(posedge clk_sys);
		#1;
	endtask

	// Sampled mid cycle, then on to the next drive point
	task automatic check_row(input logic [7:0] exp);
		@(negedge clk_sys);
		checks++;
		if (row_data !== exp) begin
			errors++;
			$display("Error at %0d ns: row_data (col %h) expected %h, got %h",
				$time, col_select, exp, row_data);
		end
		tick();
	endtask

	// Walks columns 0 to 3 and compares with the rows implied by the buttons
	task automatic check_buttons(input control_pkg::player_buttons_t a,
		input control_pkg::player_buttons_t b);
		for (int c = 0; c < 4; c++) begin
			col_select = 8'h01 << c;
			check_row(expected_row(cur_game, col_select, a, b));
		end
	endtask

	task automatic write_dl(input logic [7:0] idx, input logic [24:0] addr,
		input logic [7:0] data);
		dl = {1'b1, idx, addr, data};
		tick();
		dl.strobe = 1'b0;
		tick();  // Game decode lands here
	endtask

	task automatic select_game(input logic [7:0] code, input cabinet_cfg_pkg::game_e g);
		write_dl(cabinet_cfg_pkg::IDX_GAME_SELECT, 25'd0, code);
		cur_game = g;
	endtask

	task automatic send_key(input logic [8:0] code, input logic pressed);
		key = {~key.toggle, pressed, code};
		tick();
		tick();
	endtask

	// ====================
	// Tests
	// ====================
	task automatic test_reset();
		check_buttons('0, '0); // No game yet
	endtask

	task automatic test_space_zap();
		write_dl(cabinet_cfg_pkg::IDX_DIP, 25'd2, 8'h06);
		dip2_exp = 8'h06;
		write_dl(cabinet_cfg_pkg::IDX_DIP, 25'd3, 8'hA5);
		dip3_exp = 8'hA5;
		select_game(8'd3, cabinet_cfg_pkg::GAME_SPACE_ZAP);
		check_buttons('0, '0);
	endtask

	task automatic test_keys();
		control_pkg::player_buttons_t mask;
		for (int i = 0; i < 18; i++) begin
			mask = KEY_BTN[i][7:0];
			send_key(KEY_CODES[i], 1'b1);
			if (KEY_BTN[i][8])
				check_buttons('0, mask);
			else
				check_buttons(mask, '0);
			send_key(KEY_CODES[i], 1'b0);
			check_buttons('0, '0);
		end
		// Ctrl held while W, which has no function, is released and pressed
		mask = KEY_BTN[4][7:0];
		send_key(KEY_CODES[4], 1'b1);
		send_key(9'h01D, 1'b0);
		check_buttons(mask, '0);
		send_key(9'h01D, 1'b1);
		check_buttons(mask, '0);
		send_key(KEY_CODES[4], 1'b0);
		check_buttons('0, '0);
	endtask

	task automatic test_random();
		logic [31:0] r;
		control_pkg::player_buttons_t a;
		control_pkg::player_buttons_t b;
		for (int n = 0; n < 50; n++) begin
			r = lcg_next();
			joy_1 = r[31:16];
			r = lcg_next();
			joy_2 = r[31:16];
			r = lcg_next();
			col_select = 8'h01 << (r[31:16] % 16'd5); // Fifth pick is an idle column
			a = stick_buttons(joy_1, joy_1.start_1, joy_1.coin);
			b = stick_buttons(joy_2, joy_1.start_2, 1'b0);
			check_row(expected_row(cur_game, col_select, a, b));
		end
		joy_1 = '0;
		joy_2 = '0;
	endtask

	task automatic test_config_edges();
		// Low address bits hit bytes 0, 3 and 2 if range check were missing
		write_dl(cabinet_cfg_pkg::IDX_DIP, 25'd8, 8'h00);
		write_dl(cabinet_cfg_pkg::IDX_DIP, 25'd11, 8'h00);
		write_dl(cabinet_cfg_pkg::IDX_DIP, 25'h100002, 8'h00);
		check_buttons('0, '0);
		select_game(8'd7, cabinet_cfg_pkg::GAME_NONE);
		check_buttons('0, '0);
	endtask

	// ====================
	// Main sequence
	// ====================
	initial begin
		dl         = '0;
		key        = '0;
		joy_1      = '0;
		joy_2      = '0;
		col_select = control_pkg::COL_0;
		reset      = 1'b1;
		cur_game   = cabinet_cfg_pkg::GAME_NONE;
		dip2_exp   = 8'h00;
		dip3_exp   = 8'h00;
		lcg_state  = 32'h6d76;
		errors     = 0;
		checks     = 0;
		repeat (8) @(posedge clk_sys);
		#1;
		reset = 1'b0;
		test_reset();
		test_space_zap();
		test_keys();
		select_game(8'd5, cabinet_cfg_pkg::GAME_WIZARD_OF_WOR);
		test_keys();                 // Fire B keys show up here
		select_game(8'd6, cabinet_cfg_pkg::GAME_ROBBY_ROTO);
		test_random();
		select_game(8'd5, cabinet_cfg_pkg::GAME_WIZARD_OF_WOR);
		test_random();
		test_config_edges();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// Watchdog
	initial begin
		#((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
		$display("Timeout: the tests did not finish within the expected run time");
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: verilog.f
logic/cabinet_cfg_pkg.sv
logic/control_pkg.sv
logic/game_config.sv
logic/key_decoder.sv
logic/switch_matrix.sv
logic/cabinet_inputs.sv
dv/tb_cabinet_inputs.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the cabinet input testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module tb_cabinet_inputs -f verilog.f -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
	echo "Simulation reported failure"
	exit 1
fi

echo "Simulation finished without failures"
exit 0
